/* husky_ctrl.f */
hw/husky_ctrl_pkg.sv
hw/usb_reg_front.sv
hw/reg_trigger.sv
hw/reg_target_io.sv
hw/reg_status.sv
hw/husky_ctrl_top.sv
tb/tb_husky_ctrl.sv

/* hw/husky_ctrl_pkg.sv */
package husky_ctrl_pkg;

   // Bus widths
   localparam int DATA_W      = 8;
   localparam int ADDR_W      = 8;
   localparam int TRIG_PINS   = 5;   // io1..io4, then nRST
   localparam int BYTECNT_DEF = 7;

   // Register map
   typedef enum logic [ADDR_W-1:0] {
      ADDR_TRIG_CFG = 8'h20,   // Byte 0 mask, byte 1 mode
      ADDR_IO_CTRL  = 8'h21,
      ADDR_STATUS   = 8'h22
   } reg_addr_e;

   // Trigger combine mode
   typedef enum logic {
      TRIG_OR  = 1'b0,
      TRIG_AND = 1'b1
   } trig_mode_e;

   // Host bus front end states
   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      WRITE,
      READ
   } bus_state_e;

   // One register request, broadcast to every block
   typedef struct packed {
      logic [ADDR_W-1:0]      address;
      logic [BYTECNT_DEF-1:0] bytecnt;
      logic [DATA_W-1:0]      wdata;
      logic                   read;
      logic                   write;
   } reg_req_t;

   // Drive of one target pin
   typedef struct packed {
      logic oe;
      logic val;
   } pin_drive_t;

endpackage

/* hw/husky_ctrl_top.sv */
`timescale 1ns/10ps

module husky_ctrl_top #(
   parameter int BYTECNT_W     = 7,
   parameter int HEARTBEAT_BIT = 22
) (
   input  logic                                  clk_usb_buf,
   input  logic                                  rst_i,
   input  logic [husky_ctrl_pkg::ADDR_W-1:0]     usb_addr_i,
   input  logic [husky_ctrl_pkg::DATA_W-1:0]     usb_data_i,
   input  logic                                  usb_rdn_i,
   input  logic                                  usb_wrn_i,
   input  logic                                  usb_cen_i,
   input  logic                                  usb_alen_i,
   output logic [husky_ctrl_pkg::DATA_W-1:0]     usb_data_o,
   output logic                                  usb_data_oe_o,
   input  logic [husky_ctrl_pkg::TRIG_PINS-1:0]  trig_pins_i,
   input  logic                                  sam_mosi_i,
   input  logic                                  sam_spck_i,
   input  logic                                  target_miso_i,
   input  logic [1:0]                            error_i,
   input  logic                                  pll_locked_i,
   output logic                                  trigout_o,
   output logic                                  target_poweron_o,
   output husky_ctrl_pkg::pin_drive_t            nrst_o,
   output husky_ctrl_pkg::pin_drive_t            mosi_o,
   output husky_ctrl_pkg::pin_drive_t            sck_o,
   output husky_ctrl_pkg::pin_drive_t            sam_miso_o,
   output logic                                  led_adc_o
);

   husky_ctrl_pkg::reg_req_t          reg_req;
   logic [husky_ctrl_pkg::DATA_W-1:0] rdata_trig;
   logic [husky_ctrl_pkg::DATA_W-1:0] rdata_io;
   logic [husky_ctrl_pkg::DATA_W-1:0] rdata_status;
   logic [husky_ctrl_pkg::DATA_W-1:0] rdata_merged;

   // Unaddressed blocks return zero
   assign rdata_merged = rdata_trig | rdata_io | rdata_status;

   usb_reg_front #(
      .BYTECNT_W      (BYTECNT_W)
   ) front_i (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .usb_addr_i     (usb_addr_i),
      .usb_data_i     (usb_data_i),
      .usb_rdn_i      (usb_rdn_i),
      .usb_wrn_i      (usb_wrn_i),
      .usb_cen_i      (usb_cen_i),
      .usb_alen_i     (usb_alen_i),
      .rdata_i        (rdata_merged),
      .req_o          (reg_req),
      .usb_data_o     (usb_data_o),
      .usb_data_oe_o  (usb_data_oe_o)
   );

   reg_trigger #(
      .BYTECNT_W      (BYTECNT_W)
   ) trigger_i (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .req_i          (reg_req),
      .trig_pins_i    (trig_pins_i),
      .rdata_o        (rdata_trig),
      .trig_o         (trigout_o)
   );

   reg_target_io #(
      .BYTECNT_W        (BYTECNT_W)
   ) target_io_i (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .req_i            (reg_req),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .rdata_o          (rdata_io),
      .target_poweron_o (target_poweron_o),
      .nrst_o           (nrst_o),
      .mosi_o           (mosi_o),
      .sck_o            (sck_o),
      .sam_miso_o       (sam_miso_o)
   );

   reg_status #(
      .BYTECNT_W      (BYTECNT_W),
      .HEARTBEAT_BIT  (HEARTBEAT_BIT)
   ) status_i (
      .clk_usb_buf    (clk_usb_buf),
      .rst_i          (rst_i),
      .req_i          (reg_req),
      .error_i        (error_i),
      .pll_locked_i   (pll_locked_i),
      .rdata_o        (rdata_status),
      .led_adc_o      (led_adc_o)
   );

endmodule

/* hw/reg_status.sv */
`timescale 1ns/10ps

module reg_status #(
   parameter int BYTECNT_W     = 7,
   parameter int HEARTBEAT_BIT = 22
) (
   input  logic                               clk_usb_buf,
   input  logic                               rst_i,
   input  husky_ctrl_pkg::reg_req_t           req_i,
   input  logic [1:0]                         error_i,   // FIFO, monitor
   input  logic                               pll_locked_i,
   output logic [husky_ctrl_pkg::DATA_W-1:0]  rdata_o,
   output logic                               led_adc_o
);

   localparam int ERR_W = 2;

   logic [BYTECNT_W-1:0]   byte_sel;
   logic                   hit;
   logic [ERR_W-1:0]       err_prev_q;
   logic [ERR_W-1:0]       err_q;
   logic [ERR_W-1:0]       err_rise;
   logic [ERR_W-1:0]       err_clr;
   logic [HEARTBEAT_BIT:0] hb_q;

   assign byte_sel = BYTECNT_W'(req_i.bytecnt);
   assign hit      = (req_i.address == husky_ctrl_pkg::ADDR_STATUS) &&
                     (byte_sel == BYTECNT_W'(0));

   assign err_rise = error_i & ~err_prev_q;
   assign err_clr  = (hit && req_i.write) ? req_i.wdata[ERR_W-1:0] : '0;   // Write one to clear

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         err_prev_q <= '0;
         err_q      <= '0;
      end else begin
         err_prev_q <= error_i;
         err_q      <= (err_q & ~err_clr) | err_rise;   // New event beats a clear
      end
   end

   // Free running heartbeat
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         hb_q <= '0;
      end else begin
         hb_q <= hb_q + 1'b1;
      end
   end

   assign rdata_o = hit ? {{(husky_ctrl_pkg::DATA_W - ERR_W){1'b0}}, err_q} : '0;

   // Blink on error, else show PLL unlock
   assign led_adc_o = (|err_q) ? hb_q[HEARTBEAT_BIT] : ~pll_locked_i;

endmodule

/* hw/reg_target_io.sv */
`timescale 1ns/10ps

module reg_target_io #(
   parameter int BYTECNT_W = 7
) (
   input  logic                               clk_usb_buf,
   input  logic                               rst_i,
   input  husky_ctrl_pkg::reg_req_t           req_i,
   input  logic                               sam_mosi_i,
   input  logic                               sam_spck_i,
   input  logic                               target_miso_i,
   output logic [husky_ctrl_pkg::DATA_W-1:0]  rdata_o,
   output logic                               target_poweron_o,
   output husky_ctrl_pkg::pin_drive_t         nrst_o,
   output husky_ctrl_pkg::pin_drive_t         mosi_o,
   output husky_ctrl_pkg::pin_drive_t         sck_o,
   output husky_ctrl_pkg::pin_drive_t         sam_miso_o
);

   // Control register layout, bit 0 first from the bottom
   typedef struct packed {
      logic nrst_val;
      logic nrst_en;
      logic avrprog;
      logic power_off;
   } io_ctrl_t;

   localparam int CTRL_W = $bits(io_ctrl_t);

   logic [BYTECNT_W-1:0] byte_sel;
   logic                 hit;
   io_ctrl_t             ctrl_q;

   assign byte_sel = BYTECNT_W'(req_i.bytecnt);
   assign hit      = (req_i.address == husky_ctrl_pkg::ADDR_IO_CTRL) &&
                     (byte_sel == BYTECNT_W'(0));   // Single byte register

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         ctrl_q <= '0;
      end else if (hit && req_i.write) begin
         ctrl_q <= io_ctrl_t'(req_i.wdata[CTRL_W-1:0]);
      end
   end

   assign rdata_o = hit ? {{(husky_ctrl_pkg::DATA_W - CTRL_W){1'b0}}, ctrl_q} : '0;

   assign target_poweron_o = ~ctrl_q.power_off;

   // Pin priority: power off, then AVR programming, then nRST override
   always_comb begin
      nrst_o.oe  = 1'b0;
      nrst_o.val = ctrl_q.avrprog ? 1'b0 : ctrl_q.nrst_val;   // Hold target in reset
      mosi_o.oe  = 1'b0;
      mosi_o.val = sam_mosi_i;
      sck_o.oe   = 1'b0;
      sck_o.val  = sam_spck_i;
      if (!ctrl_q.power_off) begin
         if (ctrl_q.avrprog) begin
            nrst_o.oe = 1'b1;
            mosi_o.oe = 1'b1;
            sck_o.oe  = 1'b1;
         end else if (ctrl_q.nrst_en) begin
            nrst_o.oe = 1'b1;
         end
      end
   end

   // MISO back to the SAM ignores target power
   assign sam_miso_o.oe  = ctrl_q.avrprog;
   assign sam_miso_o.val = target_miso_i;

endmodule

/* hw/reg_trigger.sv */
`timescale 1ns/10ps

module reg_trigger #(
   parameter int BYTECNT_W = 7
) (
   input  logic                                  clk_usb_buf,
   input  logic                                  rst_i,
   input  husky_ctrl_pkg::reg_req_t              req_i,
   input  logic [husky_ctrl_pkg::TRIG_PINS-1:0]  trig_pins_i,
   output logic [husky_ctrl_pkg::DATA_W-1:0]     rdata_o,
   output logic                                  trig_o
);

   logic [BYTECNT_W-1:0]                 byte_sel;
   logic                                 hit;
   logic [husky_ctrl_pkg::TRIG_PINS-1:0] mask_q;
   husky_ctrl_pkg::trig_mode_e           mode_q;
   logic                                 any_hit;
   logic                                 all_hit;
   logic                                 trig_q;

   assign byte_sel = BYTECNT_W'(req_i.bytecnt);
   assign hit      = (req_i.address == husky_ctrl_pkg::ADDR_TRIG_CFG);

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         mask_q <= '0;
         mode_q <= husky_ctrl_pkg::TRIG_OR;
      end else if (hit && req_i.write) begin
         if (byte_sel == BYTECNT_W'(0)) begin
            mask_q <= req_i.wdata[husky_ctrl_pkg::TRIG_PINS-1:0];
         end else if (byte_sel == BYTECNT_W'(1)) begin
            mode_q <= husky_ctrl_pkg::trig_mode_e'(req_i.wdata[0]);
         end
      end
   end

   always_comb begin
      rdata_o = '0;
      if (hit) begin
         if (byte_sel == BYTECNT_W'(0)) begin
            rdata_o = {{(husky_ctrl_pkg::DATA_W - husky_ctrl_pkg::TRIG_PINS){1'b0}}, mask_q};
         end else if (byte_sel == BYTECNT_W'(1)) begin
            rdata_o = {{(husky_ctrl_pkg::DATA_W - 1){1'b0}}, mode_q};
         end
      end
   end

   // Unmasked pins count as high for AND, empty mask never fires
   assign any_hit = |(trig_pins_i & mask_q);
   assign all_hit = (&(trig_pins_i | ~mask_q)) & (|mask_q);

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         trig_q <= 1'b0;
      end else begin
         trig_q <= (mode_q == husky_ctrl_pkg::TRIG_AND) ? all_hit : any_hit;
      end
   end

   assign trig_o = trig_q;

endmodule

/* hw/usb_reg_front.sv */
`timescale 1ns/10ps

module usb_reg_front #(
   parameter int BYTECNT_W = 7
) (
   input  logic                                clk_usb_buf,
   input  logic                                rst_i,
   input  logic [husky_ctrl_pkg::ADDR_W-1:0]   usb_addr_i,
   input  logic [husky_ctrl_pkg::DATA_W-1:0]   usb_data_i,
   input  logic                                usb_rdn_i,
   input  logic                                usb_wrn_i,
   input  logic                                usb_cen_i,
   input  logic                                usb_alen_i,
   input  logic [husky_ctrl_pkg::DATA_W-1:0]   rdata_i,
   output husky_ctrl_pkg::reg_req_t            req_o,
   output logic [husky_ctrl_pkg::DATA_W-1:0]   usb_data_o,
   output logic                                usb_data_oe_o
);

   localparam int REQ_CNT_W = husky_ctrl_pkg::BYTECNT_DEF;

   // Strobe positions in the sync vectors
   localparam int RDN  = 0;
   localparam int WRN  = 1;
   localparam int CEN  = 2;
   localparam int ALEN = 3;

   logic [3:0] strb_meta;
   logic [3:0] strb_sync;
   logic [3:0] strb_prev;   // Edge detect stage

   logic cs_active;
   logic ale_active;
   logic wr_fall;
   logic wr_rise;
   logic rd_fall;
   logic rd_rise;

   husky_ctrl_pkg::bus_state_e state_q;
   husky_ctrl_pkg::bus_state_e state_d;

   logic                              addr_load;
   logic                              cnt_inc;
   logic                              wr_pulse;
   logic                              rd_pulse;
   logic [husky_ctrl_pkg::ADDR_W-1:0] addr_q;
   logic [BYTECNT_W-1:0]              cnt_q;
   logic [husky_ctrl_pkg::DATA_W-1:0] wdata_q;
   logic [husky_ctrl_pkg::DATA_W-1:0] dout_q;
   logic                              wr_q;
   logic                              rd_q;

   // Two-flop synchronizer, strobes idle high
   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         strb_meta <= '1;
         strb_sync <= '1;
         strb_prev <= '1;
      end else begin
         strb_meta <= {usb_alen_i, usb_cen_i, usb_wrn_i, usb_rdn_i};
         strb_sync <= strb_meta;
         strb_prev <= strb_sync;
      end
   end

   assign cs_active  = ~strb_sync[CEN];
   assign ale_active = cs_active & ~strb_sync[ALEN];
   assign wr_fall    = strb_prev[WRN] & ~strb_sync[WRN];
   assign wr_rise    = ~strb_prev[WRN] & strb_sync[WRN];
   assign rd_fall    = strb_prev[RDN] & ~strb_sync[RDN];
   assign rd_rise    = ~strb_prev[RDN] & strb_sync[RDN];

   always_comb begin
      state_d   = state_q;
      addr_load = 1'b0;
      cnt_inc   = 1'b0;
      wr_pulse  = 1'b0;
      rd_pulse  = 1'b0;
      case (state_q)
         husky_ctrl_pkg::IDLE,
         husky_ctrl_pkg::ADDR: begin
            if (ale_active) begin
               state_d   = husky_ctrl_pkg::ADDR;
               addr_load = 1'b1;
            end else if (cs_active && wr_fall) begin
               state_d  = husky_ctrl_pkg::WRITE;
               wr_pulse = 1'b1;
            end else if (cs_active && rd_fall) begin
               state_d  = husky_ctrl_pkg::READ;
               rd_pulse = 1'b1;
            end else begin
               state_d = husky_ctrl_pkg::IDLE;
            end
         end
         husky_ctrl_pkg::WRITE: begin
            if (wr_rise) begin
               cnt_inc = 1'b1;   // Next byte of the register
               state_d = husky_ctrl_pkg::IDLE;
            end
         end
         husky_ctrl_pkg::READ: begin
            if (rd_rise) begin
               cnt_inc = 1'b1;
               state_d = husky_ctrl_pkg::IDLE;
            end
         end
         default: state_d = husky_ctrl_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (rst_i) begin
         state_q <= husky_ctrl_pkg::IDLE;
         addr_q  <= '0;
         cnt_q   <= '0;
         wr_q    <= 1'b0;
         rd_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         wr_q    <= wr_pulse;
         rd_q    <= rd_pulse;
         if (addr_load) begin
            addr_q <= usb_addr_i;
            cnt_q  <= '0;
         end else if (cnt_inc) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // Data path
   always_ff @(posedge clk_usb_buf) begin
      if (wr_pulse) begin
         wdata_q <= usb_data_i;
      end
      if (rd_q) begin
         dout_q <= rdata_i;   // Held for the host until the next read
      end
   end

   always_comb begin
      req_o.address = addr_q;
      req_o.bytecnt = REQ_CNT_W'(cnt_q);
      req_o.wdata   = wdata_q;
      req_o.read    = rd_q;
      req_o.write   = wr_q;
   end

   assign usb_data_o    = dout_q;
   assign usb_data_oe_o = (state_q == husky_ctrl_pkg::READ);   // Drop on synced RDn rise

endmodule

/* tb/tb_husky_ctrl.sv */
`timescale 1ns/10ps

module tb_husky_ctrl;

   localparam int CLK_PERIOD = 40;
   localparam int SEED       = 32'hdcc9;

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_TRIG, OP_PINS, OP_ERR, OP_LED} op_e;

   // One table row with the expected outputs packed in exp
   typedef struct packed {
      op_e        op;
      logic [7:0] addr;
      logic [2:0] bytecnt;
      logic [7:0] data;
      logic [4:0] pins;
      logic [8:0] exp;
   } entry_t;

   logic       clk_usb_buf;
   logic       rst_i;
   logic [7:0] usb_addr_i;
   logic [7:0] usb_data_i;
   logic       usb_rdn_i;
   logic       usb_wrn_i;
   logic       usb_cen_i;
   logic       usb_alen_i;
   logic [7:0] usb_data_o;
   logic       usb_data_oe_o;
   logic [4:0] trig_pins_i;
   logic       sam_mosi_i;
   logic       sam_spck_i;
   logic       target_miso_i;
   logic [1:0] error_i;
   logic       pll_locked_i;
   logic       trigout_o;
   logic       target_poweron_o;
   logic       led_adc_o;
   husky_ctrl_pkg::pin_drive_t nrst_o;
   husky_ctrl_pkg::pin_drive_t mosi_o;
   husky_ctrl_pkg::pin_drive_t sck_o;
   husky_ctrl_pkg::pin_drive_t sam_miso_o;

   entry_t stim_q[$];
   bit     table_built;
   int     err_count;
   int     check_count;

   husky_ctrl_top #(
      .HEARTBEAT_BIT    (3)   // Blink every 8 cycles
   ) dut_i (
      .clk_usb_buf      (clk_usb_buf),
      .rst_i            (rst_i),
      .usb_addr_i       (usb_addr_i),
      .usb_data_i       (usb_data_i),
      .usb_rdn_i        (usb_rdn_i),
      .usb_wrn_i        (usb_wrn_i),
      .usb_cen_i        (usb_cen_i),
      .usb_alen_i       (usb_alen_i),
      .usb_data_o       (usb_data_o),
      .usb_data_oe_o    (usb_data_oe_o),
      .trig_pins_i      (trig_pins_i),
      .sam_mosi_i       (sam_mosi_i),
      .sam_spck_i       (sam_spck_i),
      .target_miso_i    (target_miso_i),
      .error_i          (error_i),
      .pll_locked_i     (pll_locked_i),
      .trigout_o        (trigout_o),
      .target_poweron_o (target_poweron_o),
      .nrst_o           (nrst_o),
      .mosi_o           (mosi_o),
      .sck_o            (sck_o),
      .sam_miso_o       (sam_miso_o),
      .led_adc_o        (led_adc_o)
   );

   always #(CLK_PERIOD / 2) clk_usb_buf = ~clk_usb_buf;

   // Inputs change and outputs are sampled 2 ns after each edge
   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk_usb_buf);
         #2;
      end
   endtask

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic check_pin(input husky_ctrl_pkg::pin_drive_t pin, input logic [1:0] exp,
                            input string what);
      check_eq(pin.oe, exp[1], {what, ".oe"});
      if (exp[1]) begin
         check_eq(pin.val, exp[0], {what, ".val"});   // Value only matters when driven
      end
   endtask

   function automatic logic trig_expect(input logic [4:0] pins, input logic [4:0] mask,
                                        input logic mode);
      if (mask == 5'h00) begin
         return 1'b0;
      end
      if (mode) begin
         return (pins & mask) == mask;
      end
      return |(pins & mask);
   endfunction

   // {poweron, nrst oe/val, mosi oe/val, sck oe/val, sam_miso oe/val}
   function automatic logic [8:0] pins_expect(input logic [3:0] ctrl, input logic [2:0] sam);
      logic [8:0] e;
      e    = '0;
      e[8] = ~ctrl[0];
      if (!ctrl[0] && ctrl[1]) begin
         e[7:6] = 2'b10;
         e[5:4] = {1'b1, sam[0]};
         e[3:2] = {1'b1, sam[1]};
      end else if (!ctrl[0] && ctrl[2]) begin
         e[7:6] = {1'b1, ctrl[3]};
      end
      e[1:0] = {ctrl[1], sam[2]};
      return e;
   endfunction

   function automatic void add_entry(input op_e op, input logic [7:0] addr,
                                     input logic [2:0] bytecnt, input logic [7:0] data,
                                     input logic [4:0] pins, input logic [8:0] exp);
      entry_t e;
      e.op      = op;
      e.addr    = addr;
      e.bytecnt = bytecnt;
      e.data    = data;
      e.pins    = pins;
      e.exp     = exp;
      stim_q.push_back(e);
   endfunction

   task automatic build_table();
      logic [4:0] mask;
      logic [4:0] pins;
      logic       mode;
      logic [2:0] sam;
      int         i;
      add_entry(OP_WR, husky_ctrl_pkg::ADDR_TRIG_CFG, 0, 8'h15, 0, 0);
      add_entry(OP_WR, husky_ctrl_pkg::ADDR_TRIG_CFG, 1, 8'h01, 0, 0);
      add_entry(OP_WR, husky_ctrl_pkg::ADDR_IO_CTRL, 0, 8'h0c, 0, 0);
      add_entry(OP_RD, husky_ctrl_pkg::ADDR_TRIG_CFG, 0, 0, 0, 9'h015);
      add_entry(OP_RD, husky_ctrl_pkg::ADDR_TRIG_CFG, 1, 0, 0, 9'h001);
      add_entry(OP_RD, husky_ctrl_pkg::ADDR_IO_CTRL, 0, 0, 0, 9'h00c);
      add_entry(OP_RD, husky_ctrl_pkg::ADDR_TRIG_CFG, 2, 0, 0, 9'h000);
      add_entry(OP_RD, 8'h55, 0, 0, 0, 9'h000);   // Unmapped
      for (i = 0; i < 12; i++) begin
         mask = (i < 2) ? 5'h00 : 5'($urandom);
         mode = i[0];
         pins = 5'($urandom);
         if (i % 4 == 3) begin
            pins = pins | mask;   // Give AND mode some hits
         end
         add_entry(OP_TRIG, 0, 0, {mode, 2'b00, mask}, pins,
                   {8'h00, trig_expect(pins, mask, mode)});
      end
      for (i = 0; i < 16; i++) begin
         // Each pass-through input sees both levels while driven, and differs from the others
         sam = {i[2], i[3], i[3] ^ i[2]};
         add_entry(OP_PINS, husky_ctrl_pkg::ADDR_IO_CTRL, 0, 8'(i), {2'b00, sam},
                   pins_expect(4'(i), sam));
      end
      add_entry(OP_ERR, 0, 0, 8'h01, 0, 0);
      add_entry(OP_RD, husky_ctrl_pkg::ADDR_STATUS, 0, 0, 0, 9'h001);
      add_entry(OP_ERR, 0, 0, 8'h02, 0, 0);
      add_entry(OP_RD, husky_ctrl_pkg::ADDR_STATUS, 0, 0, 0, 9'h003);
      add_entry(OP_LED, 0, 0, 8'h03, 0, 0);   // Blink with PLL locked
      add_entry(OP_WR, husky_ctrl_pkg::ADDR_STATUS, 0, 8'h01, 0, 0);
      add_entry(OP_RD, husky_ctrl_pkg::ADDR_STATUS, 0, 0, 0, 9'h002);
      add_entry(OP_WR, husky_ctrl_pkg::ADDR_STATUS, 0, 8'h02, 0, 0);
      add_entry(OP_RD, husky_ctrl_pkg::ADDR_STATUS, 0, 0, 0, 9'h000);
      add_entry(OP_LED, 0, 0, 8'h00, 0, 9'h001);
      add_entry(OP_LED, 0, 0, 8'h01, 0, 9'h000);
   endtask

   task automatic latch_addr(input logic [7:0] addr);
      usb_addr_i = addr;
      usb_cen_i  = 1'b0;
      usb_alen_i = 1'b0;
      wait_cycles(6);
      usb_alen_i = 1'b1;
      wait_cycles(3);
   endtask

   task automatic write_strobe(input logic [7:0] data);
      usb_data_i = data;
      usb_wrn_i  = 1'b0;
      wait_cycles(6);
      usb_wrn_i = 1'b1;
      wait_cycles(3);
   endtask

   task automatic read_strobe(output logic [7:0] data, output logic oe_seen);
      usb_rdn_i = 1'b0;
      wait_cycles(6);
      data      = usb_data_o;
      oe_seen   = usb_data_oe_o;
      usb_rdn_i = 1'b1;
      wait_cycles(3);
   endtask

   // Dummy reads step the byte counter without side effects
   task automatic bus_write(input logic [7:0] addr, input int bytecnt, input logic [7:0] data);
      logic [7:0] dummy;
      logic       oe;
      latch_addr(addr);
      repeat (bytecnt) read_strobe(dummy, oe);
      write_strobe(data);
      usb_cen_i = 1'b1;
      wait_cycles(2);
   endtask

   task automatic bus_read(input logic [7:0] addr, input int bytecnt, output logic [7:0] data);
      logic [7:0] dummy;
      logic       oe;
      latch_addr(addr);
      repeat (bytecnt) read_strobe(dummy, oe);
      check_eq(usb_data_oe_o, 1'b0, "usb_data_oe_o before RDn low");
      read_strobe(data, oe);
      check_eq(oe, 1'b1, "usb_data_oe_o while RDn low");
      check_eq(usb_data_oe_o, 1'b0, "usb_data_oe_o after RDn high");
      usb_cen_i = 1'b1;
      wait_cycles(2);
   endtask

   task automatic blink_check();
      logic v;
      int   n;
      int   i;
      v = led_adc_o;
      n = 0;
      while (led_adc_o == v && n < 20) begin
         wait_cycles(1);
         n++;
      end
      if (led_adc_o == v) begin
         err_count++;
         $display("LED did not blink while an error flag was set");
      end else begin
         v = led_adc_o;
         for (i = 1; i <= 24; i++) begin
            wait_cycles(1);
            check_eq(led_adc_o, v ^ ((i / 8) % 2), "led_adc_o blink");
         end
      end
   endtask

   initial begin
      wait (table_built);
      #(stim_q.size() * 40 * CLK_PERIOD);
      $display("Timeout: the table did not finish in the allotted time");
      $display("Something failed");
      $finish;
   end

   initial begin
      entry_t     e;
      logic [7:0] rd;
      clk_usb_buf   = 1'b0;
      rst_i         = 1'b1;
      usb_addr_i    = '0;
      usb_data_i    = '0;
      usb_rdn_i     = 1'b1;
      usb_wrn_i     = 1'b1;
      usb_cen_i     = 1'b1;
      usb_alen_i    = 1'b1;
      trig_pins_i   = '0;
      sam_mosi_i    = 1'b0;
      sam_spck_i    = 1'b0;
      target_miso_i = 1'b0;
      error_i       = '0;
      pll_locked_i  = 1'b1;
      err_count     = 0;
      check_count   = 0;
      void'($urandom(SEED));
      build_table();
      table_built = 1'b1;

      repeat (5) @(posedge clk_usb_buf);
      #2;
      rst_i = 1'b0;
      wait_cycles(1);
      check_eq(usb_data_oe_o, 1'b0, "usb_data_oe_o after reset");
      check_eq(trigout_o, 1'b0, "trigout_o after reset");
      check_eq(target_poweron_o, 1'b1, "target_poweron_o after reset");
      check_eq({nrst_o.oe, mosi_o.oe, sck_o.oe, sam_miso_o.oe}, 4'h0, "pin oe after reset");
      check_eq(led_adc_o, 1'b0, "led_adc_o after reset");

      foreach (stim_q[k]) begin
         e = stim_q[k];
         case (e.op)
            OP_WR: bus_write(e.addr, e.bytecnt, e.data);
            OP_RD: begin
               bus_read(e.addr, e.bytecnt, rd);
               check_eq(rd, e.exp[7:0], $sformatf("read %h byte %0d", e.addr, e.bytecnt));
            end
            OP_TRIG: begin
               latch_addr(husky_ctrl_pkg::ADDR_TRIG_CFG);
               write_strobe({3'b000, e.data[4:0]});   // Mask in byte 0
               write_strobe({7'h00, e.data[7]});      // Mode in byte 1
               usb_cen_i   = 1'b1;
               trig_pins_i = e.pins;
               wait_cycles(3);
               check_eq(trigout_o, e.exp[0],
                        $sformatf("trigout_o mask %h mode %0d pins %h",
                                  e.data[4:0], e.data[7], e.pins));
            end
            OP_PINS: begin
               bus_write(husky_ctrl_pkg::ADDR_IO_CTRL, 0, e.data);
               {target_miso_i, sam_spck_i, sam_mosi_i} = e.pins[2:0];
               wait_cycles(1);
               check_eq(target_poweron_o, e.exp[8], "target_poweron_o");
               check_pin(nrst_o, e.exp[7:6], "nrst_o");
               check_pin(mosi_o, e.exp[5:4], "mosi_o");
               check_pin(sck_o, e.exp[3:2], "sck_o");
               check_pin(sam_miso_o, e.exp[1:0], "sam_miso_o");
            end
            OP_ERR: begin
               error_i = e.data[1:0];
               wait_cycles(1);
               error_i = '0;
               wait_cycles(2);
            end
            default: begin
               pll_locked_i = e.data[0];
               wait_cycles(1);
               if (e.data[1]) begin
                  blink_check();
               end else begin
                  check_eq(led_adc_o, e.exp[0], "led_adc_o");
               end
            end
         endcase
      end

      $display("Checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
